// File: am_envelope.sv
// AM envelope detector: clamped I/Q magnitudes, then max plus half min.
module am_envelope (
	input  logic           clk,
	input  logic           RSTb,
	input  sdr_pkg::iq_t   iq,
	input  logic           tick,
	output sdr_pkg::wide_t audio,
	output logic           audio_tick
);

	logic [6:0] mag_i;
	logic [6:0] mag_q;
	logic [6:0] abs_i;
	logic [6:0] abs_q;
	logic [6:0] mag_max;
	logic [6:0] mag_min;
	logic [8:0] env;
	logic mag_vld;

	// Absolute value, -128 pinned to 127.
	function automatic logic [6:0] mag7(input sdr_pkg::sample_t x);
		logic [7:0] neg;
		neg = -x;
		if (x == -8'sd128)
			return 7'd127;
		else if (x[7])
			return neg[6:0];
		else
			return x[6:0];
	endfunction

	assign abs_i = mag7(iq.i);
	assign abs_q = mag7(iq.q);

	// Step one, magnitudes on the sample strobe.
	always_ff @(posedge clk) begin
		if (tick) begin
			mag_i <= abs_i;
			mag_q <= abs_q;
		end
	end

	assign mag_max = (mag_i > mag_q) ? mag_i : mag_q;
	assign mag_min = (mag_i > mag_q) ? mag_q : mag_i;
	assign env = {2'b00, mag_max} + {3'b000, mag_min[6:1]}; // Alpha 1, beta 1/2.

	// Step two, scaled into the audio word.
	always_ff @(posedge clk) begin
		if (!RSTb) begin
			mag_vld <= 1'b0;
			audio <= '0;
			audio_tick <= 1'b0;
		end else begin
			mag_vld <= tick;
			audio_tick <= mag_vld;
			if (mag_vld)
				audio <= {env, 7'd0};
		end
	end

endmodule

// File: audio_pwm.sv
// Audio PWM: free-running 8-bit counter against a gain-selected byte of the sample.
module audio_pwm (
	input  logic           clk,
	input  logic           RSTb,
	input  sdr_pkg::wide_t audio,
	input  sdr_pkg::gain_t gain,
	output logic           pwm_out
);

	logic [7:0] count;
	logic [7:0] level;

	// Higher gain takes a lower slice; bits above it are dropped.
	always_comb begin
		case (gain[2:0])
			3'd0:    level = audio[15:8];
			3'd1:    level = audio[14:7];
			3'd2:    level = audio[13:6];
			3'd3:    level = audio[12:5];
			3'd4:    level = audio[11:4];
			default: level = audio[10:3];
		endcase
	end

	always_ff @(posedge clk) begin
		if (!RSTb) begin
			count <= '0;
			pwm_out <= 1'b0;
		end else begin
			count <= count + 1'b1; // 256-cycle frame.
			pwm_out <= (count < level);
		end
	end

endmodule

// File: cic_decimator.sv
// CIC decimator: N integrators, decimation counter, N combs and scaled 16-bit output.
module cic_decimator #(
	parameter int CIC_R = 8,
	parameter int CIC_N = 3
) (
	input  logic             clk,
	input  logic             RSTb,
	input  logic             ce,
	input  sdr_pkg::sample_t din,
	output sdr_pkg::wide_t   dout,
	output logic             tick
);

	localparam int IN_W = $bits(sdr_pkg::sample_t);
	localparam int OUT_W = $bits(sdr_pkg::wide_t);
	// Bit growth is N * log2(R).
	localparam int W = IN_W + CIC_N * $clog2(CIC_R);
	localparam int CNT_W = (CIC_R > 1) ? $clog2(CIC_R) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CIC_R - 1);

	logic signed [W-1:0] integ [CIC_N];
	logic signed [W-1:0] dly [CIC_N];
	logic signed [W-1:0] comb [CIC_N+1];
	logic [CNT_W-1:0] dec_cnt;
	logic dec;

	assign dec = ce && (dec_cnt == CNT_LAST);

	// Integrator chain, first stage takes the sign-extended input.
	always_ff @(posedge clk) begin
		if (!RSTb) begin
			for (int k = 0; k < CIC_N; k++)
				integ[k] <= '0;
		end else if (ce) begin
			integ[0] <= integ[0] + W'(din);
			for (int k = 1; k < CIC_N; k++)
				integ[k] <= integ[k] + integ[k-1];
		end
	end

	// Counts enabled cycles only.
	always_ff @(posedge clk) begin
		if (!RSTb)
			dec_cnt <= '0;
		else if (dec)
			dec_cnt <= '0;
		else if (ce)
			dec_cnt <= dec_cnt + 1'b1;
	end

	// Comb chain at the low rate.
	always_comb begin
		comb[0] = integ[CIC_N-1];
		for (int k = 0; k < CIC_N; k++)
			comb[k+1] = comb[k] - dly[k];
	end

	always_ff @(posedge clk) begin
		if (!RSTb) begin
			for (int k = 0; k < CIC_N; k++)
				dly[k] <= '0;
			dout <= '0;
			tick <= 1'b0;
		end else begin
			tick <= dec; // Single cycle per output.
			if (dec) begin
				for (int k = 0; k < CIC_N; k++)
					dly[k] <= comb[k];
				dout <= comb[CIC_N][W-1 -: OUT_W]; // Top bits, held until next tick.
			end
		end
	end

endmodule

// File: nco_quadrature.sv
// Quadrature NCO: phase accumulator with registered square-wave cosine and sine.
module nco_quadrature (
	input  logic            clk,
	input  logic            RSTb,
	input  sdr_pkg::phase_t phase_inc,
	output sdr_pkg::iq_t    lo
);

	localparam int MSB = sdr_pkg::PHASE_W - 1;
	localparam sdr_pkg::sample_t AMP_POS = sdr_pkg::sample_t'(sdr_pkg::SINE_AMP);
	localparam sdr_pkg::sample_t AMP_NEG = sdr_pkg::sample_t'(-sdr_pkg::SINE_AMP);

	sdr_pkg::phase_t acc;
	logic sin_pos;
	logic cos_pos;

	always_ff @(posedge clk) begin
		if (!RSTb)
			acc <= '0;
		else
			acc <= acc + phase_inc; // Wraps modulo 2^26.
	end

	// Top two phase bits pick the quadrant.
	assign sin_pos = ~acc[MSB];
	assign cos_pos = (acc[MSB] == acc[MSB-1]);

	// Cosine leads sine by a quarter turn.
	always_ff @(posedge clk) begin
		lo.i <= cos_pos ? AMP_POS : AMP_NEG;
		lo.q <= sin_pos ? AMP_POS : AMP_NEG;
	end

endmodule

// File: rf_mixer.sv
// One-bit RF sampler with comparator echo and quadrature mixer against the NCO.
module rf_mixer (
	input  logic         clk,
	input  logic         RSTb,
	input  logic         comp_in,
	input  sdr_pkg::iq_t lo,
	output logic         comp_out,
	output sdr_pkg::iq_t mix
);

	logic rf_q;

	// Sampled RF bit, also the comparator feedback.
	always_ff @(posedge clk) begin
		if (!RSTb)
			rf_q <= 1'b0;
		else
			rf_q <= comp_in;
	end

	assign comp_out = rf_q;

	// Bit as +1 or -1 times the LO pair.
	// LO never reaches -128, so negation cannot overflow.
	always_ff @(posedge clk) begin
		if (rf_q) begin
			mix.i <= lo.i;
			mix.q <= lo.q;
		end else begin
			mix.i <= -lo.i;
			mix.q <= -lo.q;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module sdr_receiver_tb -f tb.f \
	&& { out=$(./obj_dir/Vsdr_receiver_tb 2>&1); printf '%s\n' "$out"; } \
	&& printf '%s\n' "$out" | grep -q "TESTBENCH PASSED" \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed"; exit 1; }

// File: sdr_pkg.sv
// Receiver package: widths, sample and config typedefs, IQ and config structs, fixed constants.
package sdr_pkg;

	// NCO phase accumulator and tuning word.
	localparam int PHASE_W = 26;
	typedef logic [PHASE_W-1:0] phase_t;

	// Audio gain field from the SPI frame.
	localparam int GAIN_W = 4;
	typedef logic [GAIN_W-1:0] gain_t;

	// Signed samples from the NCO through to the CIC inputs.
	typedef logic signed [7:0] sample_t;

	// CIC outputs and the demodulated audio word.
	typedef logic [15:0] wide_t;

	// One quadrature sample pair.
	typedef struct packed {
		sample_t i;
		sample_t q;
	} iq_t;

	// Configuration written over SPI.
	typedef struct packed {
		phase_t phase_inc;
		gain_t  gain;
	} cfg_t;

	// Full SPI write frame, MSB first.
	localparam int SPI_FRAME_W = 32;

	// Square-wave NCO amplitude.
	localparam int SINE_AMP = 127;

endpackage

// File: sdr_receiver.sv
// Receiver top: SPI config, NCO, mixer, two CIC pairs, envelope detector and PWM.
module sdr_receiver #(
	parameter int CIC_R = 8,
	parameter int CIC_N = 3
) (
	input  logic clk,
	input  logic RSTb,
	input  logic comp_in,
	output logic comp_out,
	output logic pwm_out,
	input  logic sck,
	input  logic mosi,
	input  logic cs
);

	sdr_pkg::cfg_t cfg;
	sdr_pkg::iq_t lo;
	sdr_pkg::iq_t mix;
	sdr_pkg::iq_t env_iq;
	sdr_pkg::wide_t x1_i;
	sdr_pkg::wide_t x1_q;
	sdr_pkg::wide_t x2_i;
	sdr_pkg::wide_t x2_q;
	sdr_pkg::wide_t audio;
	logic tick1_i;
	logic tick1_q;
	logic tick2_i;
	logic tick2_q;
	logic audio_tick;

	spi_config spi_config_inst (
		.clk  (clk),
		.RSTb (RSTb),
		.sck  (sck),
		.mosi (mosi),
		.cs   (cs),
		.cfg  (cfg)
	);

	nco_quadrature nco_quadrature_inst (
		.clk       (clk),
		.RSTb      (RSTb),
		.phase_inc (cfg.phase_inc),
		.lo        (lo)
	);

	rf_mixer rf_mixer_inst (
		.clk      (clk),
		.RSTb     (RSTb),
		.comp_in  (comp_in),
		.lo       (lo),
		.comp_out (comp_out),
		.mix      (mix)
	);

	// First stage at the full clock rate.
	cic_decimator #(.CIC_R(CIC_R), .CIC_N(CIC_N)) cic1_i_inst (
		.clk  (clk),
		.RSTb (RSTb),
		.ce   (1'b1),
		.din  (mix.i),
		.dout (x1_i),
		.tick (tick1_i)
	);

	cic_decimator #(.CIC_R(CIC_R), .CIC_N(CIC_N)) cic1_q_inst (
		.clk  (clk),
		.RSTb (RSTb),
		.ce   (1'b1),
		.din  (mix.q),
		.dout (x1_q),
		.tick (tick1_q)
	);

	// Second stage runs on the first stage's ticks.
	cic_decimator #(.CIC_R(CIC_R), .CIC_N(CIC_N)) cic2_i_inst (
		.clk  (clk),
		.RSTb (RSTb),
		.ce   (tick1_i),
		.din  (x1_i[15:8]),
		.dout (x2_i),
		.tick (tick2_i)
	);

	cic_decimator #(.CIC_R(CIC_R), .CIC_N(CIC_N)) cic2_q_inst (
		.clk  (clk),
		.RSTb (RSTb),
		.ce   (tick1_q),
		.din  (x1_q[15:8]),
		.dout (x2_q),
		.tick (tick2_q)
	);

	assign env_iq.i = x2_i[15:8];
	assign env_iq.q = x2_q[15:8];

	am_envelope am_envelope_inst (
		.clk        (clk),
		.RSTb       (RSTb),
		.iq         (env_iq),
		.tick       (tick2_i), // Both pairs tick together.
		.audio      (audio),
		.audio_tick (audio_tick)
	);

	audio_pwm audio_pwm_inst (
		.clk     (clk),
		.RSTb    (RSTb),
		.audio   (audio),
		.gain    (cfg.gain),
		.pwm_out (pwm_out)
	);

endmodule

// File: sdr_receiver_props.sv
// Concurrent checks on reset outputs, comparator echo, CIC tick width and audio strobe, bound to the receiver.
module sdr_receiver_props (
	input logic clk,
	input logic RSTb,
	input logic comp_in,
	input logic comp_out,
	input logic pwm_out,
	input logic tick1_i,
	input logic tick1_q,
	input logic tick2_i,
	input logic tick2_q,
	input logic audio_tick
);
	timeunit 1ns;
	timeprecision 100ps;

	// Both registered outputs are cleared by a reset edge.
	reset_outputs_low: assert property (@(posedge clk) !RSTb |=> (!pwm_out && !comp_out))
		else $error("pwm_out or comp_out high after a reset edge");

	comparator_echo: assert property (@(posedge clk) disable iff (!RSTb)
		RSTb |=> (comp_out == $past(comp_in)))
		else $error("comp_out does not follow comp_in by one clock");

	// Ticks are single-cycle strobes.
	tick1_i_pulse: assert property (@(posedge clk) disable iff (!RSTb) tick1_i |=> !tick1_i)
		else $error("first I CIC tick longer than one cycle");
	tick1_q_pulse: assert property (@(posedge clk) disable iff (!RSTb) tick1_q |=> !tick1_q)
		else $error("first Q CIC tick longer than one cycle");
	tick2_i_pulse: assert property (@(posedge clk) disable iff (!RSTb) tick2_i |=> !tick2_i)
		else $error("second I CIC tick longer than one cycle");
	tick2_q_pulse: assert property (@(posedge clk) disable iff (!RSTb) tick2_q |=> !tick2_q)
		else $error("second Q CIC tick longer than one cycle");

	// Audio strobe trails the second I tick through both envelope steps.
	audio_strobe: assert property (@(posedge clk) disable iff (!RSTb) tick2_i |-> ##2 audio_tick)
		else $error("audio_tick missing two cycles after the second I CIC tick");

endmodule

bind sdr_receiver sdr_receiver_props sdr_receiver_props_inst (
	.clk        (clk),
	.RSTb       (RSTb),
	.comp_in    (comp_in),
	.comp_out   (comp_out),
	.pwm_out    (pwm_out),
	.tick1_i    (tick1_i),
	.tick1_q    (tick1_q),
	.tick2_i    (tick2_i),
	.tick2_q    (tick2_q),
	.audio_tick (audio_tick)
);

// File: sdr_receiver_tb.sv
// Receiver testbench: SPI driver, LFSR, expected duty model, duty compare process and watchdog.
module sdr_receiver_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CIC_R = 8;
	localparam int CIC_N = 3;
	localparam int PERIOD_NS = 8;
	localparam int RESET_CYCLES = 16;
	localparam int SPI_HALF = 8; // SCK half period in clocks.
	localparam int SETTLE = 2048;
	localparam int WINDOW = 256;
	localparam int POST_RESET = 48; // Well before the first audio sample.
	localparam int ECHO_BITS = 256;
	localparam int N_STEPS = 16;
	localparam int FRAME_CYCLES = 2 * SPI_HALF * (sdr_pkg::SPI_FRAME_W + 2);
	localparam int STEP_CYCLES = FRAME_CYCLES + SETTLE + WINDOW + 4;
	localparam int TEST_CYCLES = RESET_CYCLES + POST_RESET + ECHO_BITS + N_STEPS * STEP_CYCLES;
	localparam int WATCHDOG_NS = (TEST_CYCLES + TEST_CYCLES / 4) * PERIOD_NS;
	localparam int CIC_DC_GAIN = CIC_R ** CIC_N;

	logic clk;
	logic RSTb;
	logic comp_in;
	logic comp_out;
	logic pwm_out;
	logic sck;
	logic mosi;
	logic cs;

	logic [31:0] lfsr_state = 32'hfee1_c107;
	event window_start;
	event window_done;
	string window_name;
	logic [7:0] window_exp;

	tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) tb_clock_inst (
		.clk  (clk),
		.RSTb (RSTb)
	);

	sdr_receiver #(.CIC_R(CIC_R), .CIC_N(CIC_N)) sdr_receiver_inst (
		.clk      (clk),
		.RSTb     (RSTb),
		.comp_in  (comp_in),
		.comp_out (comp_out),
		.pwm_out  (pwm_out),
		.sck      (sck),
		.mosi     (mosi),
		.cs       (cs)
	);

	// Taps 32, 22, 2, 1.
	function automatic logic random_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return lfsr_state[0];
	endfunction

	// Duty for a steady comparator level with tuning word zero.
	function automatic logic [7:0] expected_duty(input logic level, input sdr_pkg::gain_t gain);
		int lo_amp;
		int v;
		int mag;
		int env;
		int g;
		int lsb;
		sdr_pkg::wide_t audio_w;
		lo_amp = sdr_pkg::SINE_AMP; // Phase stays at 0, so sine and cosine are both high.
		v = level ? lo_amp : -lo_amp;
		// Each CIC: DC gain, output drop of one bit, then the top byte.
		v = (v * CIC_DC_GAIN / 2) >>> 8;
		v = (v * CIC_DC_GAIN / 2) >>> 8;
		mag = (v < 0) ? -v : v;
		if (mag > 127)
			mag = 127;
		env = mag + mag / 2; // I and Q equal, so max plus half min.
		audio_w = sdr_pkg::wide_t'(env << 7);
		g = int'(gain[2:0]);
		lsb = (g >= 5) ? 3 : 8 - g;
		return 8'(audio_w >> lsb);
	endfunction

	function automatic logic [31:0] build_frame(input sdr_pkg::phase_t tuning,
			input sdr_pkg::gain_t gain);
		return {2'b00, tuning, gain};
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_duty(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected)
			stop_on_error($sformatf("FAILED %s: expected duty %0d, actual %0d",
				name, expected, actual));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stop_on_error($sformatf("FAILED %s: expected %b, actual %b",
				name, expected, actual));
	endtask

	// MSB first, MOSI changes while SCK is low.
	task automatic send_frame(input logic [31:0] frame, input int nbits);
		@(posedge clk);
		cs <= 1'b0;
		repeat (SPI_HALF) @(posedge clk);
		for (int k = nbits - 1; k >= 0; k--) begin
			mosi <= frame[k];
			repeat (SPI_HALF) @(posedge clk);
			sck <= 1'b1;
			repeat (SPI_HALF) @(posedge clk);
			sck <= 1'b0;
		end
		repeat (SPI_HALF) @(posedge clk);
		cs <= 1'b1;
		repeat (SPI_HALF) @(posedge clk); // Covers the config update delay.
	endtask

	task automatic measure_duty(input string name, input logic [7:0] expected);
		window_name = name;
		window_exp = expected;
		-> window_start;
		@(window_done);
	endtask

	task automatic configure_and_measure(input string name, input logic level,
			input sdr_pkg::gain_t gain);
		send_frame(build_frame('0, gain), sdr_pkg::SPI_FRAME_W);
		repeat (SETTLE) @(posedge clk);
		measure_duty(name, expected_duty(level, gain));
	endtask

	// Counts high PWM cycles over one frame and compares.
	initial begin : duty_window
		int highs;
		forever begin
			@(window_start);
			highs = 0;
			repeat (WINDOW) begin
				@(negedge clk);
				if (pwm_out)
					highs++;
			end
			if (highs > 255)
				stop_on_error($sformatf("%s: pwm_out stayed high for a whole frame", window_name));
			check_duty(window_name, window_exp, 8'(highs));
			-> window_done;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : main
		logic prev;
		logic b;
		comp_in = 1'b0;
		sck = 1'b0;
		mosi = 1'b0;
		cs = 1'b1;

		// Reset state.
		@(negedge clk);
		while (!RSTb) begin
			check_bit("reset pwm_out", 1'b0, pwm_out);
			check_bit("reset comp_out", 1'b0, comp_out);
			@(negedge clk);
		end
		repeat (POST_RESET) begin
			check_bit("post-reset pwm_out", 1'b0, pwm_out);
			check_bit("post-reset comp_out", 1'b0, comp_out);
			@(negedge clk);
		end

		// Comparator echo with random bits.
		prev = comp_in;
		repeat (ECHO_BITS) begin
			@(posedge clk);
			b = random_bit();
			comp_in <= b;
			@(negedge clk);
			check_bit("comparator echo", prev, comp_out);
			prev = b;
		end

		@(posedge clk);
		comp_in <= 1'b1;
		configure_and_measure("gain 0 tone", 1'b1, 4'd0);

		for (int g = 1; g <= 6; g++)
			configure_and_measure($sformatf("gain sweep %0d", g), 1'b1, sdr_pkg::gain_t'(g));

		// Opposite polarity, same magnitudes.
		@(posedge clk);
		comp_in <= 1'b0;
		for (int g = 0; g <= 6; g++)
			configure_and_measure($sformatf("polarity gain %0d", g), 1'b0, sdr_pkg::gain_t'(g));

		// A 31-bit frame must leave gain 3 in place.
		configure_and_measure("before short frame", 1'b0, 4'd3);
		send_frame(build_frame('0, 4'd1), sdr_pkg::SPI_FRAME_W - 1);
		repeat (SETTLE) @(posedge clk);
		measure_duty("short frame ignored", expected_duty(1'b0, 4'd3));

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: spi_config.sv
// SPI slave: pin synchronizers, 32-bit frame shifter, bit counter and config latch.
module spi_config (
	input  logic          clk,
	input  logic          RSTb,
	input  logic          sck,
	input  logic          mosi,
	input  logic          cs,
	output sdr_pkg::cfg_t cfg
);

	localparam int FRAME_W = sdr_pkg::SPI_FRAME_W;
	localparam int CNT_W = $clog2(FRAME_W) + 1;
	localparam logic [CNT_W-1:0] FRAME_BITS = CNT_W'(FRAME_W);
	localparam int GAIN_W = sdr_pkg::GAIN_W;
	localparam int PHASE_W = sdr_pkg::PHASE_W;

	typedef enum logic {
		ST_IDLE,
		ST_SHIFT
	} spi_state_t;

	spi_state_t state;
	logic [2:0] sck_s;
	logic [1:0] mosi_s;
	logic [1:0] cs_s;
	logic sck_rise;
	logic [CNT_W-1:0] bit_cnt;
	logic [FRAME_W-1:0] shift_q;
	logic frame_ok;

	// Two flops per pin, plus one extra on SCK for the edge.
	always_ff @(posedge clk) begin
		if (!RSTb) begin
			sck_s <= '0;
			mosi_s <= '0;
			cs_s <= 2'b11; // Deselected.
		end else begin
			sck_s <= {sck_s[1:0], sck};
			mosi_s <= {mosi_s[0], mosi};
			cs_s <= {cs_s[0], cs};
		end
	end

	assign sck_rise = sck_s[1] & ~sck_s[2];

	always_ff @(posedge clk) begin
		if (!RSTb) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			frame_ok <= 1'b0;
		end else begin
			frame_ok <= 1'b0;
			case (state)
				ST_IDLE: begin
					bit_cnt <= '0;
					if (!cs_s[1])
						state <= ST_SHIFT;
				end
				ST_SHIFT: begin
					if (cs_s[1]) begin
						// CS released, frame counts only at exactly 32 edges.
						state <= ST_IDLE;
						frame_ok <= (bit_cnt == FRAME_BITS);
					end else if (sck_rise && bit_cnt != '1) begin
						bit_cnt <= bit_cnt + 1'b1; // Saturates on long frames.
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// MSB first into the bottom.
	always_ff @(posedge clk) begin
		if (state == ST_SHIFT && sck_rise)
			shift_q <= {shift_q[FRAME_W-2:0], mosi_s[1]};
	end

	// Bits 31:30 are don't care.
	always_ff @(posedge clk) begin
		if (!RSTb) begin
			cfg <= '0;
		end else if (frame_ok) begin
			cfg.phase_inc <= shift_q[PHASE_W+GAIN_W-1:GAIN_W];
			cfg.gain <= shift_q[GAIN_W-1:0];
		end
	end

endmodule

// File: tb.f
sdr_pkg.sv
spi_config.sv
nco_quadrature.sv
rf_mixer.sv
cic_decimator.sv
am_envelope.sv
audio_pwm.sv
sdr_receiver.sv
tb_clock.sv
sdr_receiver_props.sv
sdr_receiver_tb.sv

// File: tb_clock.sv
// Testbench clock and synchronous reset generator.
module tb_clock #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic RSTb
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset held low for a fixed count of rising edges.
	initial begin
		RSTb = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		RSTb <= 1'b1;
	end

endmodule
